//--- rtl/busPkg.sv
package busPkg;

  // Byte address, used on the processor side and on the bus
  typedef logic [31:0] addrT;

  // One data word
  typedef logic [31:0] wordT;

  // One enable bit per byte lane of a word
  typedef logic [3:0] byteMaskT;

endpackage

//--- rtl/cachePkg.sv
package cachePkg;

  // Geometry used when the top level is not overridden
  localparam int defaultLines = 16;
  localparam int defaultBlockWords = 4;

  // Miss handling sequence of the controller
  //   idle       hits are served, a miss starts the sequence
  //   writeBack  dirty victim goes out word by word
  //   refill     new block comes in word by word
  //   settle     one cycle for the arrays before the retry
  typedef enum logic [1:0] {
    idle,
    writeBack,
    refill,
    settle
  } ctrlStateT;

endpackage

//--- rtl/cacheWay.sv
`timescale 1ns/1ps

module cacheWay #(
  parameter int lines = cachePkg::defaultLines,
  parameter int blockWords = cachePkg::defaultBlockWords,
  localparam int indexW = $clog2(lines),
  localparam int offsetW = $clog2(blockWords),
  localparam int tagW = 32 - 2 - offsetW - indexW
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [indexW-1:0]  index,
  input  logic [tagW-1:0]    tagIn,
  input  logic [offsetW-1:0] wordSel,
  input  logic              wordWe,
  input  busPkg::byteMaskT  byteMask,
  input  busPkg::wordT      wData,
  input  logic              fill,
  input  logic              setDirty,
  input  logic              clearDirty,
  output logic              hit,
  output logic              valid,
  output logic              dirty,
  output logic [tagW-1:0]    tagOut,
  output busPkg::wordT      rData
);

  import busPkg::*;

  wordT            dataMem [lines][blockWords];
  logic [tagW-1:0] tagMem [lines];
  logic [lines-1:0] validBits;
  logic [lines-1:0] dirtyBits;

  // Data array with byte lanes written separately
  always_ff @(posedge clk) begin
    if (wordWe) begin
      for (int b = 0; b < 4; b++) begin
        if (byteMask[b]) begin
          dataMem[index][wordSel][8*b +: 8] <= wData[8*b +: 8];
        end
      end
    end
  end

  // Tag is written once per refill
  always_ff @(posedge clk) begin
    if (fill) begin
      tagMem[index] <= tagIn;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (fill) begin
      validBits[index] <= 1'b1;
    end
  end

  // Write hit marks the line, refill cleans it
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      dirtyBits <= '0;
    end else if (setDirty) begin
      dirtyBits[index] <= 1'b1;
    end else if (clearDirty) begin
      dirtyBits[index] <= 1'b0;
    end
  end

  assign valid  = validBits[index];
  assign dirty  = dirtyBits[index];
  assign tagOut = tagMem[index];
  assign hit    = valid && (tagOut == tagIn);
  assign rData  = dataMem[index][wordSel];

  // A refill and a write hit belong to different controller states
  fillNotWithDirty: assert property (
    @(posedge clk) disable iff (reset) !(fill && setDirty)
  );

endmodule

//--- rtl/cacheController.sv
`timescale 1ns/1ps

module cacheController #(
  parameter int lines = cachePkg::defaultLines,
  parameter int blockWords = cachePkg::defaultBlockWords,
  localparam int indexW = $clog2(lines),
  localparam int offsetW = $clog2(blockWords),
  localparam int tagW = 32 - 2 - offsetW - indexW
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               cpuRead,
  input  logic               cpuWrite,
  input  busPkg::addrT       cpuAddr,
  input  busPkg::byteMaskT   cpuByteMask,
  input  busPkg::wordT       cpuWData,
  output logic               stall,
  output busPkg::wordT       cpuRData,
  output logic [indexW-1:0]  way0Index,
  output logic [tagW-1:0]    way0TagIn,
  output logic [offsetW-1:0] way0WordSel,
  output logic               way0WordWe,
  output busPkg::byteMaskT   way0ByteMask,
  output busPkg::wordT       way0WData,
  output logic               way0Fill,
  output logic               way0SetDirty,
  output logic               way0ClearDirty,
  input  logic               way0Hit,
  input  logic               way0Valid,
  input  logic               way0Dirty,
  input  logic [tagW-1:0]    way0TagOut,
  input  busPkg::wordT       way0RData,
  output logic [indexW-1:0]  way1Index,
  output logic [tagW-1:0]    way1TagIn,
  output logic [offsetW-1:0] way1WordSel,
  output logic               way1WordWe,
  output busPkg::byteMaskT   way1ByteMask,
  output busPkg::wordT       way1WData,
  output logic               way1Fill,
  output logic               way1SetDirty,
  output logic               way1ClearDirty,
  input  logic               way1Hit,
  input  logic               way1Valid,
  input  logic               way1Dirty,
  input  logic [tagW-1:0]    way1TagOut,
  input  busPkg::wordT       way1RData,
  output logic               busRequest,
  output logic               busWrite,
  output busPkg::addrT       busAddr,
  output busPkg::wordT       busWData,
  input  busPkg::wordT       busRData,
  input  logic               busReady
);

  import busPkg::*;
  import cachePkg::*;

  ctrlStateT          state;
  ctrlStateT          nextState;
  logic [offsetW-1:0] wordCount;
  logic               victimWay;
  logic [lines-1:0]   lru;

  logic [indexW-1:0]  cpuIndex;
  logic [tagW-1:0]    cpuTag;
  logic [offsetW-1:0] cpuWord;
  logic               access;
  logic               anyHit;
  logic               miss;
  logic               victimSel;
  logic               victimDirty;
  logic [tagW-1:0]    victimTag;
  wordT               victimData;
  logic               lastWord;
  logic               wordDone;
  logic               writeHit;
  logic               fillDone;
  logic [offsetW-1:0] wordSel;
  byteMaskT           wayMask;
  wordT               wayData;

  // Address fields from low to high are byte, word offset, index and tag
  assign cpuWord  = cpuAddr[2 +: offsetW];
  assign cpuIndex = cpuAddr[2 + offsetW +: indexW];
  assign cpuTag   = cpuAddr[31 -: tagW];

  assign access = cpuRead || cpuWrite;
  assign anyHit = way0Hit || way1Hit;
  assign miss   = access && !anyHit;

  // Empty way first, LRU way otherwise
  always_comb begin
    if (!way0Valid) begin
      victimSel = 1'b0;
    end else if (!way1Valid) begin
      victimSel = 1'b1;
    end else begin
      victimSel = lru[cpuIndex];
    end
  end

  assign victimDirty = victimSel ? way1Dirty : way0Dirty;
  assign victimTag   = victimWay ? way1TagOut : way0TagOut;
  assign victimData  = victimWay ? way1RData : way0RData;
  assign cpuRData    = way1Hit ? way1RData : way0RData;

  assign lastWord = (wordCount == offsetW'(blockWords - 1));
  assign wordDone = busReady && (state == writeBack || state == refill);
  assign writeHit = (state == idle) && cpuWrite && anyHit;
  assign fillDone = (state == refill) && busReady && lastWord;

  always_comb begin
    nextState = state;
    case (state)
      idle:      if (miss) nextState = victimDirty ? writeBack : refill;
      writeBack: if (busReady && lastWord) nextState = refill;
      refill:    if (busReady && lastWord) nextState = settle;
      settle:    nextState = idle;
      default:   nextState = idle;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= idle;
      wordCount <= '0;
      victimWay <= 1'b0;
    end else begin
      state <= nextState;
      if (state == idle && miss) begin
        victimWay <= victimSel;
        wordCount <= '0;
      end else if (wordDone) begin
        wordCount <= lastWord ? '0 : wordCount + 1'b1;
      end
    end
  end

  // LRU bit names the way not used last
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lru <= '0;
    end else if (state == idle && access && anyHit) begin
      lru[cpuIndex] <= way0Hit;
    end
  end

  assign stall = (state != idle) || miss;

  // Bus fields come from state and counter only, so they hold under back-pressure
  assign busRequest = (state == writeBack) || (state == refill);
  assign busWrite   = (state == writeBack);
  assign busAddr    = {(state == writeBack) ? victimTag : cpuTag, cpuIndex, wordCount, 2'b00};
  assign busWData   = victimData;

  // Refill words or a processor write hit
  assign wordSel = (state == idle) ? cpuWord : wordCount;
  assign wayMask = (state == idle) ? cpuByteMask : 4'hF;
  assign wayData = (state == idle) ? cpuWData : busRData;

  assign way0Index   = cpuIndex;
  assign way0TagIn   = cpuTag;
  assign way0WordSel = wordSel;
  assign way0ByteMask = wayMask;
  assign way0WData   = wayData;
  assign way0WordWe  = (writeHit && way0Hit) ||
                       (state == refill && busReady && !victimWay);
  assign way0Fill       = fillDone && !victimWay;
  assign way0ClearDirty = fillDone && !victimWay;
  assign way0SetDirty   = writeHit && way0Hit;

  assign way1Index   = cpuIndex;
  assign way1TagIn   = cpuTag;
  assign way1WordSel = wordSel;
  assign way1ByteMask = wayMask;
  assign way1WData   = wayData;
  assign way1WordWe  = (writeHit && way1Hit) ||
                       (state == refill && busReady && victimWay);
  assign way1Fill       = fillDone && victimWay;
  assign way1ClearDirty = fillDone && victimWay;
  assign way1SetDirty   = writeHit && way1Hit;

  // A block lives in at most one way
  oneWayHits: assert property (
    @(posedge clk) disable iff (reset) !(way0Hit && way1Hit)
  );

  busHoldsWhileWaiting: assert property (
    @(posedge clk) disable iff (reset)
    busRequest && !busReady |=> busRequest && $stable(busAddr) &&
                                $stable(busWrite) && $stable(busWData)
  );

endmodule

//--- rtl/dataCache.sv
`timescale 1ns/1ps

module dataCache #(
  parameter int lines = cachePkg::defaultLines,
  parameter int blockWords = cachePkg::defaultBlockWords,
  localparam int indexW = $clog2(lines),
  localparam int offsetW = $clog2(blockWords),
  localparam int tagW = 32 - 2 - offsetW - indexW
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cpuRead,
  input  logic             cpuWrite,
  input  busPkg::addrT     cpuAddr,
  input  busPkg::byteMaskT cpuByteMask,
  input  busPkg::wordT     cpuWData,
  output logic             stall,
  output busPkg::wordT     cpuRData,
  output logic             busRequest,
  output logic             busWrite,
  output busPkg::addrT     busAddr,
  output busPkg::wordT     busWData,
  input  busPkg::wordT     busRData,
  input  logic             busReady
);

  import busPkg::*;

  // Controller to way
  logic [indexW-1:0]  way0Index, way1Index;
  logic [tagW-1:0]    way0TagIn, way1TagIn;
  logic [offsetW-1:0] way0WordSel, way1WordSel;
  logic               way0WordWe, way1WordWe;
  byteMaskT           way0ByteMask, way1ByteMask;
  wordT               way0WData, way1WData;
  logic               way0Fill, way1Fill;
  logic               way0SetDirty, way1SetDirty;
  logic               way0ClearDirty, way1ClearDirty;

  // Way to controller
  logic               way0Hit, way1Hit;
  logic               way0Valid, way1Valid;
  logic               way0Dirty, way1Dirty;
  logic [tagW-1:0]    way0TagOut, way1TagOut;
  wordT               way0RData, way1RData;

  cacheWay #(.lines(lines), .blockWords(blockWords)) way0Inst (
    .clk, .reset,
    .index(way0Index), .tagIn(way0TagIn), .wordSel(way0WordSel),
    .wordWe(way0WordWe), .byteMask(way0ByteMask), .wData(way0WData),
    .fill(way0Fill), .setDirty(way0SetDirty), .clearDirty(way0ClearDirty),
    .hit(way0Hit), .valid(way0Valid), .dirty(way0Dirty),
    .tagOut(way0TagOut), .rData(way0RData)
  );

  cacheWay #(.lines(lines), .blockWords(blockWords)) way1Inst (
    .clk, .reset,
    .index(way1Index), .tagIn(way1TagIn), .wordSel(way1WordSel),
    .wordWe(way1WordWe), .byteMask(way1ByteMask), .wData(way1WData),
    .fill(way1Fill), .setDirty(way1SetDirty), .clearDirty(way1ClearDirty),
    .hit(way1Hit), .valid(way1Valid), .dirty(way1Dirty),
    .tagOut(way1TagOut), .rData(way1RData)
  );

  cacheController #(.lines(lines), .blockWords(blockWords)) controllerInst (
    .clk, .reset,
    .cpuRead, .cpuWrite, .cpuAddr, .cpuByteMask, .cpuWData, .stall, .cpuRData,
    .way0Index, .way0TagIn, .way0WordSel, .way0WordWe, .way0ByteMask, .way0WData,
    .way0Fill, .way0SetDirty, .way0ClearDirty,
    .way0Hit, .way0Valid, .way0Dirty, .way0TagOut, .way0RData,
    .way1Index, .way1TagIn, .way1WordSel, .way1WordWe, .way1ByteMask, .way1WData,
    .way1Fill, .way1SetDirty, .way1ClearDirty,
    .way1Hit, .way1Valid, .way1Dirty, .way1TagOut, .way1RData,
    .busRequest, .busWrite, .busAddr, .busWData, .busRData, .busReady
  );

endmodule

//--- verif/memModel.sv
`timescale 1ns/1ps

module memModel #(
  parameter busPkg::wordT fillPattern = 32'h0000_0000,
  parameter int memWords = 8192
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         busRequest,
  input  logic         busWrite,
  input  busPkg::addrT busAddr,
  input  busPkg::wordT busWData,
  output busPkg::wordT busRData,
  output logic         busReady
);

  import busPkg::*;

  localparam int wordAddrW = $clog2(memWords);

  wordT                 mem [memWords];
  logic                 readyReg = 1'b0;
  int                   idleLeft = 0;
  int                   gap;
  logic [wordAddrW-1:0] wordAddr;

  // Each word starts as its byte address mixed with the pattern
  initial begin
    for (int i = 0; i < memWords; i++) begin
      mem[i] = addrT'(i * 4) ^ fillPattern;
    end
  end

  assign wordAddr = busAddr[2 +: wordAddrW];
  assign busRData = mem[wordAddr];
  assign busReady = readyReg;

  // Write lands at the edge that completes the word
  always @(posedge clk) begin
    if (busRequest && busReady && busWrite) begin
      mem[wordAddr] <= busWData;
    end
  end

  // Ready moves on the falling edge after 0 to 3 idle cycles per word
  always @(negedge clk or posedge reset) begin
    if (reset) begin
      readyReg <= 1'b0;
      idleLeft <= 0;
    end else begin
      gap = readyReg ? int'($urandom_range(3, 0)) : idleLeft;
      readyReg <= busRequest && (gap == 0);
      idleLeft <= (busRequest && gap > 0) ? gap - 1 : gap;
    end
  end

endmodule

//--- verif/dataCacheTb.sv
`timescale 1ns/1ps

module dataCacheTb;

  import busPkg::*;
  import cachePkg::*;

  localparam int cacheLines = defaultLines;
  localparam int cacheBlockWords = defaultBlockWords;
  localparam wordT fillPattern = 32'hC0DE_5A17;
  localparam int accessTimeout = 200;

  logic     clk;
  logic     reset;
  logic     cpuRead;
  logic     cpuWrite;
  addrT     cpuAddr;
  byteMaskT cpuByteMask;
  wordT     cpuWData;
  logic     stall;
  wordT     cpuRData;
  logic     busRequest;
  logic     busWrite;
  addrT     busAddr;
  wordT     busWData;
  wordT     busRData;
  logic     busReady;

  wordT shadow [addrT];
  addrT writeBackAddrs [$];
  int   dataErrors = 0;
  int   protocolErrors = 0;
  int   timeoutErrors = 0;

  dataCache #(.lines(cacheLines), .blockWords(cacheBlockWords)) dataCache_inst (
    .clk, .reset, .cpuRead, .cpuWrite, .cpuAddr, .cpuByteMask, .cpuWData, .stall, .cpuRData,
    .busRequest, .busWrite, .busAddr, .busWData, .busRData, .busReady
  );

  memModel #(.fillPattern(fillPattern)) memInst (
    .clk, .reset, .busRequest, .busWrite, .busAddr, .busWData, .busRData, .busReady
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Memory contents as the processor has written them
  function automatic wordT shadowWord(input addrT addr);
    addrT wordAddr;
    wordAddr = {addr[31:2], 2'b00};
    if (shadow.exists(wordAddr)) begin
      return shadow[wordAddr];
    end
    return wordAddr ^ fillPattern;
  endfunction

  task automatic mergeShadow(input addrT addr, input byteMaskT mask, input wordT data);
    wordT merged;
    merged = shadowWord(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    shadow[{addr[31:2], 2'b00}] = merged;
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT expected);
    assert (got === expected) else begin
      dataErrors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic expected);
    assert (got === expected) else begin
      dataErrors++;
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, expected);
    end
  endtask

  busFieldsHold: assert property (
    @(posedge clk) disable iff (reset)
    busRequest && !busReady |=> busRequest && $stable(busAddr) &&
                                $stable(busWrite) && $stable(busWData)
  ) else begin
    protocolErrors++;
    $display("Bus request dropped or changed at %0t before busReady", $time);
  end

  stallWhileBusy: assert property (
    @(posedge clk) disable iff (reset) busRequest |-> stall
  ) else begin
    protocolErrors++;
    $display("Processor was released at %0t while a bus transfer was open", $time);
  end

  // Every write-back word is compared with the processor's view of memory
  always @(posedge clk) begin
    if (!reset && busRequest && busReady && busWrite) begin
      writeBackAddrs.push_back(busAddr);
      checkWord("busWData", busWData, shadowWord(busAddr));
    end
  end

  // One processor access, held until stall is seen low
  task automatic runAccess(input logic isWrite, input addrT addr, input byteMaskT mask,
                           input wordT data, output wordT readData, output logic sawBus,
                           output int stallCycles);
    logic      accepted;
    ctrlStateT stateSeen;
    accepted = 1'b0;
    sawBus = 1'b0;
    stallCycles = 0;
    readData = '0;
    @(negedge clk);
    cpuRead = !isWrite;
    cpuWrite = isWrite;
    cpuAddr = addr;
    cpuByteMask = mask;
    cpuWData = data;
    while (!accepted && stallCycles < accessTimeout) begin
      #1;
      if (busRequest) begin
        sawBus = 1'b1;
      end
      if (!stall) begin
        readData = cpuRData;
        accepted = 1'b1;
        @(posedge clk);
        if (isWrite) begin
          mergeShadow(addr, mask, data);
        end
      end else begin
        stallCycles++;
        @(negedge clk);
      end
    end
    if (!accepted) begin
      timeoutErrors++;
      stateSeen = dataCache_inst.controllerInst.state;
      $display("Timeout: access to %h never completed, controller stuck in %s",
               addr, stateSeen.name());
    end
  endtask

  task automatic readAndCheck(input addrT addr, input logic expectBus);
    wordT readData;
    logic sawBus;
    int   stallCycles;
    runAccess(1'b0, addr, 4'h0, '0, readData, sawBus, stallCycles);
    checkWord("cpuRData", readData, shadowWord(addr));
    checkFlag("busRequest", sawBus, expectBus);
    checkFlag("stall", stallCycles > 0, expectBus);
  endtask

  task automatic writeWord(input addrT addr, input byteMaskT mask, input wordT data,
                           input logic expectBus);
    wordT readData;
    logic sawBus;
    int   stallCycles;
    runAccess(1'b1, addr, mask, data, readData, sawBus, stallCycles);
    checkFlag("busRequest", sawBus, expectBus);
    checkFlag("stall", stallCycles > 0, expectBus);
  endtask

  task automatic checkWriteBack(input addrT blockBase);
    checkWord("busWrite words", wordT'(writeBackAddrs.size()), wordT'(cacheBlockWords));
    for (int i = 0; i < writeBackAddrs.size(); i++) begin
      checkWord("busAddr", writeBackAddrs[i], blockBase + addrT'(4 * i));
    end
  endtask

  initial begin
    void'($urandom(17158));
    reset = 1'b1;
    cpuRead = 1'b0;
    cpuWrite = 1'b0;
    cpuAddr = '0;
    cpuByteMask = '0;
    cpuWData = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    checkFlag("busRequest", busRequest, 1'b0);
    checkFlag("stall", stall, 1'b0);

    // Miss then hit in the same block
    readAndCheck(32'h0000_4014, 1'b1);
    readAndCheck(32'h0000_4018, 1'b0);

    // Byte lanes merged on a write hit
    writeWord(32'h0000_4018, 4'b0101, 32'hA5A5_5A5A, 1'b0);
    readAndCheck(32'h0000_4018, 1'b0);
    writeWord(32'h0000_4018, 4'b1000, 32'h3C00_0000, 1'b0);
    readAndCheck(32'h0000_4018, 1'b0);

    // C must push out B in set 5
    readAndCheck(32'h0000_1050, 1'b1);
    readAndCheck(32'h0000_2054, 1'b1);
    readAndCheck(32'h0000_1058, 1'b0);
    readAndCheck(32'h0000_305C, 1'b1);
    readAndCheck(32'h0000_1050, 1'b0);
    readAndCheck(32'h0000_2050, 1'b1);

    // Dirty block in set 9 goes back before F comes in
    writeWord(32'h0000_5098, 4'hF, 32'h1234_5678, 1'b1);
    readAndCheck(32'h0000_6090, 1'b1);
    writeBackAddrs.delete();
    readAndCheck(32'h0000_7094, 1'b1);
    checkWriteBack(32'h0000_5090);
    readAndCheck(32'h0000_5098, 1'b1);

    @(negedge clk);
    cpuRead = 1'b0;
    cpuWrite = 1'b0;
    repeat (2) @(negedge clk);
    $display("Errors: %0d data, %0d protocol, %0d timeout",
             dataErrors, protocolErrors, timeoutErrors);
    if (dataErrors == 0 && protocolErrors == 0 && timeoutErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/busPkg.sv
rtl/cachePkg.sv
rtl/cacheWay.sv
rtl/cacheController.sv
rtl/dataCache.sv
verif/memModel.sv
verif/dataCacheTb.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module dataCacheTb \
  -Mdir obj_dir -o dataCacheSim
./obj_dir/dataCacheSim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
